//--- design/cache_pkg.sv
package cache_pkg;

    // data path and address width
    localparam int WORD_W = 32;

    // address split for the data cache
    localparam int DTAG_W = 26;
    localparam int DIDX_W = 3;
    localparam int DBLK_W = 1;
    localparam int DBYT_W = 2;

    // cache geometry
    localparam int NUM_WAYS   = 2;
    localparam int NUM_FRAMES = 8;

    // backing memory
    localparam int MEM_WORDS = 256;
    localparam int MEM_WAIT  = 2;

    typedef logic [WORD_W-1:0] word_t;

    // byte address as the cache sees it
    typedef struct packed {
        logic [DTAG_W-1:0] tag;
        logic [DIDX_W-1:0] idx;
        logic [DBLK_W-1:0] blkoff;
        logic [DBYT_W-1:0] bytoff;
    } dcachef_t;

    // one frame, two words per block
    typedef struct packed {
        logic              valid;
        logic              dirty;
        logic [DTAG_W-1:0] tag;
        word_t [1:0]       data;
    } dcache_frame_t;

    // datapath side request
    typedef struct packed {
        logic  ren;
        logic  wen;
        word_t addr;
        word_t store;
    } dcache_req_t;

    // memory side request, strobes held until dwait drops
    typedef struct packed {
        logic  ren;
        logic  wen;
        word_t addr;
        word_t store;
    } mem_req_t;

    typedef enum logic [3:0] {
        COMPARE_TAG,
        WRITE_BACK1,
        WRITE_BACK2,
        ALLOCATE1,
        ALLOCATE2,
        FLUSH_SCAN,
        FLUSH_WB1,
        FLUSH_WB2,
        FLUSH_DONE
    } dcache_state_t;

endpackage

//--- design/dcache.sv
`timescale 1ns/1ps

module dcache (
    input  logic                  CLK,
    input  logic                  nRST,
    input  cache_pkg::dcache_req_t dmem_req,
    input  logic                  halt,
    output logic                  dhit,
    output cache_pkg::word_t      dmemload,
    output logic                  flushed,
    output cache_pkg::mem_req_t   mem_req,
    input  logic                  dwait,
    input  cache_pkg::word_t      dload
);

    import cache_pkg::*;

    dcache_state_t state, next_state;

    dcache_frame_t [NUM_WAYS-1:0][NUM_FRAMES-1:0] frames, next_frames;
    logic lru, next_lru;

    // flush walk counter, top bit picks the way
    logic [DIDX_W:0] fidx, next_fidx;

    dcachef_t           req;
    logic [NUM_WAYS-1:0] way_hit;
    logic               hit;
    logic               hit_way;
    dcache_frame_t      victim;
    dcache_frame_t      fframe;

    // block aligned word address from its parts
    function automatic word_t blk_addr(
        input logic [DTAG_W-1:0] tag,
        input logic [DIDX_W-1:0] idx,
        input logic [DBLK_W-1:0] blk
    );
        dcachef_t a;
        a.tag    = tag;
        a.idx    = idx;
        a.blkoff = blk;
        a.bytoff = '0;
        return word_t'(a);
    endfunction

    assign req = dcachef_t'(dmem_req.addr);

    always_comb begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            way_hit[w] = frames[w][req.idx].valid && (frames[w][req.idx].tag == req.tag);
        end
    end

    assign hit     = |way_hit;
    // two ways only, so the upper way bit names the hit
    assign hit_way = way_hit[1];
    assign victim  = frames[lru][req.idx];
    assign fframe  = frames[fidx[DIDX_W]][fidx[DIDX_W-1:0]];
    assign flushed = (state == FLUSH_DONE);

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state  <= COMPARE_TAG;
            frames <= '0;
            lru    <= 1'b0;
            fidx   <= '0;
        end else begin
            state  <= next_state;
            frames <= next_frames;
            lru    <= next_lru;
            fidx   <= next_fidx;
        end
    end

    always_comb begin
        next_state  = state;
        next_frames = frames;
        next_lru    = lru;
        next_fidx   = fidx;
        dhit        = 1'b0;
        dmemload    = 32'hBAD1_BAD1;
        mem_req     = '0;

        case (state)
            COMPARE_TAG: begin
                if (halt) begin
                    next_state = FLUSH_SCAN;
                    next_fidx  = '0;
                end else if (dmem_req.ren || dmem_req.wen) begin
                    if (hit) begin
                        dhit     = 1'b1;
                        dmemload = frames[hit_way][req.idx].data[req.blkoff];
                        if (dmem_req.wen) begin
                            dmemload = dmem_req.store;
                            next_frames[hit_way][req.idx].data[req.blkoff] = dmem_req.store;
                            next_frames[hit_way][req.idx].dirty = 1'b1;
                        end
                    end else if (victim.valid && victim.dirty) begin
                        next_state = WRITE_BACK1;
                    end else begin
                        next_state = ALLOCATE1;
                    end
                end
            end

            // victim goes back under its own tag
            WRITE_BACK1: begin
                mem_req.wen   = 1'b1;
                mem_req.addr  = blk_addr(victim.tag, req.idx, 1'b0);
                mem_req.store = victim.data[0];
                if (!dwait) begin
                    next_state = WRITE_BACK2;
                end
            end

            WRITE_BACK2: begin
                mem_req.wen   = 1'b1;
                mem_req.addr  = blk_addr(victim.tag, req.idx, 1'b1);
                mem_req.store = victim.data[1];
                if (!dwait) begin
                    next_frames[lru][req.idx].dirty = 1'b0;
                    next_state = ALLOCATE1;
                end
            end

            ALLOCATE1: begin
                mem_req.ren  = 1'b1;
                mem_req.addr = blk_addr(req.tag, req.idx, 1'b0);
                if (!dwait) begin
                    // frame is half filled until the second word lands
                    next_frames[lru][req.idx].valid   = 1'b0;
                    next_frames[lru][req.idx].data[0] = dload;
                    next_state = ALLOCATE2;
                end
            end

            ALLOCATE2: begin
                mem_req.ren  = 1'b1;
                mem_req.addr = blk_addr(req.tag, req.idx, 1'b1);
                if (!dwait) begin
                    next_frames[lru][req.idx].valid   = 1'b1;
                    next_frames[lru][req.idx].dirty   = 1'b0;
                    next_frames[lru][req.idx].tag     = req.tag;
                    next_frames[lru][req.idx].data[1] = dload;

                    dhit     = 1'b1;
                    dmemload = req.blkoff[0] ? dload : frames[lru][req.idx].data[0];

                    // write miss, merge store into the new block
                    if (dmem_req.wen) begin
                        dmemload = dmem_req.store;
                        next_frames[lru][req.idx].data[req.blkoff] = dmem_req.store;
                        next_frames[lru][req.idx].dirty = 1'b1;
                    end

                    next_lru   = ~lru;
                    next_state = COMPARE_TAG;
                end
            end

            FLUSH_SCAN: begin
                if (fframe.valid && fframe.dirty) begin
                    next_state = FLUSH_WB1;
                end else if (fidx == '1) begin
                    next_state = FLUSH_DONE;
                end else begin
                    next_fidx = fidx + 1'b1;
                end
            end

            FLUSH_WB1: begin
                mem_req.wen   = 1'b1;
                mem_req.addr  = blk_addr(fframe.tag, fidx[DIDX_W-1:0], 1'b0);
                mem_req.store = fframe.data[0];
                if (!dwait) begin
                    next_state = FLUSH_WB2;
                end
            end

            FLUSH_WB2: begin
                mem_req.wen   = 1'b1;
                mem_req.addr  = blk_addr(fframe.tag, fidx[DIDX_W-1:0], 1'b1);
                mem_req.store = fframe.data[1];
                if (!dwait) begin
                    // scan sees it clean next and moves on
                    next_frames[fidx[DIDX_W]][fidx[DIDX_W-1:0]].dirty = 1'b0;
                    next_state = FLUSH_SCAN;
                end
            end

            FLUSH_DONE: begin
                if (!halt) begin
                    next_state = COMPARE_TAG;
                    next_fidx  = '0;
                end
            end

            default: begin
                next_state = COMPARE_TAG;
            end
        endcase
    end

endmodule

//--- design/data_ram.sv
`timescale 1ns/1ps

module data_ram (
    input  logic                CLK,
    input  logic                nRST,
    input  cache_pkg::mem_req_t mem_req,
    output logic                dwait,
    output cache_pkg::word_t    dload
);

    import cache_pkg::*;

    word_t mem [MEM_WORDS];

    logic [$clog2(MEM_WAIT+1)-1:0] wait_cnt;
    logic [$clog2(MEM_WORDS)-1:0]  widx;
    logic                          strobe;
    logic                          done;

    assign strobe = mem_req.ren | mem_req.wen;

    // word address, wraps at the memory depth
    assign widx = mem_req.addr[DBYT_W +: $clog2(MEM_WORDS)];

    // access finishes once MEM_WAIT strobe cycles have passed
    assign done  = strobe && (wait_cnt == MEM_WAIT);
    assign dwait = ~done;

    // read data is simply the addressed word
    assign dload = mem[widx];

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            wait_cnt <= '0;
        end else if (!strobe || done) begin
            // back to zero so a back to back access waits again
            wait_cnt <= '0;
        end else begin
            wait_cnt <= wait_cnt + 1'b1;
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < MEM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (done && mem_req.wen) begin
            mem[widx] <= mem_req.store;
        end
    end

endmodule

//--- design/cache_subsys.sv
`timescale 1ns/1ps

module cache_subsys (
    input  logic                   CLK,
    input  logic                   nRST,
    input  cache_pkg::dcache_req_t dmem_req,
    input  logic                   halt,
    output logic                   dhit,
    output cache_pkg::word_t       dmemload,
    output logic                   flushed
);

    import cache_pkg::*;

    // cache to memory nets
    mem_req_t mem_req;
    logic     dwait;
    word_t    dload;

    dcache dcache_inst (
        .CLK      (CLK),
        .nRST     (nRST),
        .dmem_req (dmem_req),
        .halt     (halt),
        .dhit     (dhit),
        .dmemload (dmemload),
        .flushed  (flushed),
        .mem_req  (mem_req),
        .dwait    (dwait),
        .dload    (dload)
    );

    data_ram data_ram_inst (
        .CLK     (CLK),
        .nRST    (nRST),
        .mem_req (mem_req),
        .dwait   (dwait),
        .dload   (dload)
    );

endmodule

//--- dv/tb_cache_subsys.sv
`timescale 1ns/1ps

module tb_cache_subsys;

    import cache_pkg::*;

    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 5;
    localparam int REQ_COUNT    = 40;
    localparam int REQ_CYCLES   = 20;
    localparam int FLUSH_CYCLES = 200;
    // no dhit until the last cycle of the second memory read
    localparam int CLEAN_MISS_CYCLES = 2 * (MEM_WAIT + 1);

    logic        CLK;
    logic        nRST;
    dcache_req_t dmem_req;
    logic        halt;
    logic        dhit;
    word_t       dmemload;
    logic        flushed;

    // flat model of the backing memory
    word_t  model_mem [MEM_WORDS];
    integer seed;

    cache_subsys cache_subsys_inst (
        .CLK      (CLK),
        .nRST     (nRST),
        .dmem_req (dmem_req),
        .halt     (halt),
        .dhit     (dhit),
        .dmemload (dmemload),
        .flushed  (flushed)
    );

    initial begin
        CLK = 1'b0;
        forever #(CLK_PERIOD / 2) CLK = ~CLK;
    end

    initial begin
        #((RESET_CYCLES + REQ_COUNT * REQ_CYCLES + FLUSH_CYCLES) * CLK_PERIOD);
        $display("watchdog expired, the tests did not finish in time");
        $display("TEST FAILED");
        $fatal(1, "watchdog timeout");
    end

    // word address modulo the memory depth
    function automatic int model_index(input word_t addr);
        return int'((addr >> DBYT_W) % MEM_WORDS);
    endfunction

    task automatic expect_word(input word_t addr, input word_t got, input word_t exp);
        assert (got === exp) else begin
            $display("ERR %0t: address %h returned %h, expected %h", $time, addr, got, exp);
            $display("TEST FAILED");
            $fatal(1, "data mismatch");
        end
    endtask

    task automatic expect_true(input logic cond, input string msg);
        assert (cond) else begin
            $display("%0t: %s", $time, msg);
            $display("TEST FAILED");
            $fatal(1, "check failed");
        end
    endtask

    // present one request and hold it until dhit
    task automatic run_request(input logic wr, input word_t addr, input word_t data,
                               output int cycles);
        dcache_req_t r;
        word_t       exp;
        r.ren   = !wr;
        r.wen   = wr;
        r.addr  = addr;
        r.store = data;
        exp     = wr ? data : model_mem[model_index(addr)];
        cycles  = 0;
        @(posedge CLK);
        dmem_req <= r;
        @(negedge CLK);
        while (!dhit) begin
            cycles++;
            expect_true(cycles < REQ_CYCLES,
                        $sformatf("request to %h got no dhit within %0d cycles", addr, cycles));
            @(negedge CLK);
        end
        expect_word(addr, dmemload, exp);
        if (wr) begin
            model_mem[model_index(addr)] = data;
        end
        @(posedge CLK);
        dmem_req <= '0;
    endtask

    task automatic reads_after_reset();
        int c;
        run_request(1'b0, 32'h0000_0044, '0, c);
        expect_true(c > 0, "first read after reset did not miss");
        run_request(1'b0, 32'h0000_0044, '0, c);
        expect_true(c == 0, "reread of a filled word was not a hit");
        run_request(1'b0, 32'h0000_0040, '0, c);
        expect_true(c == 0, "read of the block partner word was not a hit");
    endtask

    task automatic write_read_same();
        int c;
        run_request(1'b1, 32'h0000_0108, 32'hCAFE_0108, c);
        run_request(1'b0, 32'h0000_0108, '0, c);
        // partner word keeps its old value
        run_request(1'b0, 32'h0000_010C, '0, c);
    endtask

    task automatic dirty_eviction();
        word_t addrs [3] = '{32'h0000_0068, 32'h0000_00A8, 32'h0000_00E8};
        int    c;
        // three tags share one index across two ways
        for (int i = 0; i < 3; i++) begin
            run_request(1'b1, addrs[i], 32'h5A5A_0000 | addrs[i], c);
        end
        for (int i = 0; i < 3; i++) begin
            run_request(1'b0, addrs[i], '0, c);
        end
    endtask

    task automatic random_traffic();
        word_t addr;
        word_t data;
        int    c;
        for (int i = 0; i < 4; i++) begin
            addr = $random(seed) & 32'h0000_03FC;
            data = $random(seed);
            run_request(1'b1, addr, data, c);
            addr = $random(seed) & 32'h0000_03FC;
            run_request(1'b0, addr, '0, c);
        end
    endtask

    task automatic halt_flush();
        word_t orig [2] = '{32'h0000_0030, 32'h0000_03F4};
        word_t evict_addr;
        int    c;
        int    waited;
        run_request(1'b1, orig[0], 32'hF1F1_0030, c);
        run_request(1'b1, orig[1], 32'hF1F1_03F4, c);
        @(posedge CLK);
        halt <= 1'b1;
        waited = 0;
        @(negedge CLK);
        while (!flushed) begin
            waited++;
            expect_true(waited < FLUSH_CYCLES, "flushed did not rise after halt");
            @(negedge CLK);
        end
        repeat (4) begin
            @(negedge CLK);
            expect_true(flushed, "flushed dropped while halt was still high");
        end
        @(posedge CLK);
        halt <= 1'b0;
        @(negedge CLK);
        @(negedge CLK);
        expect_true(!flushed, "flushed stayed high after halt dropped");
        // tags above the memory range were never cached before
        for (int i = 0; i < NUM_FRAMES; i++) begin
            for (int t = 1; t <= NUM_WAYS; t++) begin
                evict_addr = word_t'((t << 12) | (i << 3));
                run_request(1'b0, evict_addr, '0, c);
                expect_true(c == CLEAN_MISS_CYCLES, "eviction after flush wrote back a frame");
            end
        end
        for (int i = 0; i < 2; i++) begin
            run_request(1'b0, orig[i], '0, c);
            expect_true(c > 0, "reread after eviction did not miss");
        end
    endtask

    initial begin
        nRST     = 1'b0;
        halt     = 1'b0;
        dmem_req = '0;
        seed     = 32'he20c_c2f2;
        for (int i = 0; i < MEM_WORDS; i++) begin
            model_mem[i] = '0;
        end
        repeat (RESET_CYCLES) @(posedge CLK);
        nRST <= 1'b1;

        reads_after_reset();
        write_read_same();
        dirty_eviction();
        random_traffic();
        halt_flush();

        $display("TEST OK");
        $finish;
    end

endmodule

//--- filelist.f
design/cache_pkg.sv
design/dcache.sv
design/data_ram.sv
design/cache_subsys.sv
dv/tb_cache_subsys.sv

//--- Bender.yml
package:
  name: cache_subsys

sources:
  - design/cache_pkg.sv
  - design/dcache.sv
  - design/data_ram.sv
  - design/cache_subsys.sv
  - target: simulation
    files:
      - dv/tb_cache_subsys.sv
